/* filelist.f */
source/dlc_pkg.sv
source/sample_fifo.sv
source/level_tracker.sv
source/dlc_controller.sv
source/packet_builder.sv
source/dlc_top.sv
testbench/tb_dlc.sv

/* run_sim.sh */
#!/bin/sh
# builds the level-crossing encoder testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
  --top-module tb_dlc \
  -f filelist.f \
  -o tb_dlc_sim

out=$(./obj_dir/tb_dlc_sim)
echo "$out"

# the testbench prints the pass line only when every check held
if echo "$out" | grep -q "Result: PASSED"; then
  exit 0
else
  exit 1
fi

/* source/dlc_controller.sv */
`timescale 1ns/100ps
`default_nettype none

// encoder FSM, FIFO handshakes and delta-time counting
module dlc_controller import dlc_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    in_empty_i,  // input FIFO empty
  input  wire logic                    out_full_i,  // output FIFO full
  input  wire logic                    xing_i,
  input  wire logic                    dlvl_ovf_i,  // fresh delta-level overflow
  input  wire logic                    ovf_end_i,   // last overflow piece going out
  input  wire logic [field_bits_w-1:0] dt_bits_i,
  output logic                         pop_o,
  output logic                         push_o,
  output dlc_state_e                   state_o,
  output logic      [sample_width-1:0] dt_o
);

  dlc_state_e              state_q;
  dlc_state_e              state_d;
  logic [sample_width-1:0] dt_mask;
  logic [sample_width-1:0] skip_cnt;  // samples since last packet
  logic                    skip_en;
  logic                    skip_rst;

  assign dt_mask = field_mask(dt_bits_i);
  assign state_o = state_q;

  // take a sample only in run and only if a packet could be stored
  assign pop_o = ~in_empty_i & ~out_full_i & (state_q == run);

  always_comb begin
    state_d = state_q;
    case (state_q)
      run: begin
        if (dlvl_ovf_i && !out_full_i) begin
          state_d = dlvl_ovf;  // split a big delta
        end else if (skip_en && (skip_cnt == dt_mask)) begin
          state_d = dt_ovf;    // flat run filled the dt field
        end
      end
      dlvl_ovf: begin
        if (ovf_end_i) begin
          state_d = run;
        end
      end
      dt_ovf: begin
        if (!out_full_i) begin
          state_d = run;  // overflow packet accepted
        end
      end
      default: state_d = run;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= run;
    end else begin
      state_q <= state_d;
    end
  end

  // count only popped samples that stay on the same level
  assign skip_en  = ~xing_i & pop_o;
  assign skip_rst = xing_i | ((state_q == dt_ovf) & ~out_full_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      skip_cnt <= '0;
    end else if (skip_rst) begin
      skip_cnt <= sample_width'(1);  // current sample counts as one
    end else if (skip_en) begin
      skip_cnt <= skip_cnt + 1'b1;
    end
  end

  always_comb begin
    if (state_q == dt_ovf) begin
      dt_o = dt_mask;      // saturated delta-time
    end else if (dlvl_ovf_i) begin
      dt_o = skip_cnt;     // first piece carries the real time
    end else if (state_q == dlvl_ovf) begin
      dt_o = '0;           // follow-on pieces are back to back
    end else begin
      dt_o = skip_cnt;
    end
  end

  always_comb begin
    push_o = 1'b0;
    if (!out_full_i) begin
      if ((xing_i && state_q == run) ||
          dlvl_ovf_i ||
          state_q == dlvl_ovf ||
          state_q == dt_ovf) begin
        push_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/dlc_pkg.sv */
`default_nettype none

package dlc_pkg;

  // datapath width of samples, levels, deltas and packets
  localparam int unsigned sample_width = 16;
  localparam int unsigned log_width_w  = 4;  // log2 level width config
  localparam int unsigned field_bits_w = 4;  // field size config

  // encoder FSM states
  typedef enum logic [1:0] {
    run,       // normal sample processing
    dlvl_ovf,  // emitting split delta-level pieces
    dt_ovf     // emitting a delta-time overflow packet
  } dlc_state_e;

  // mask with the given number of low ones
  function automatic logic [sample_width-1:0] field_mask(
    input logic [field_bits_w-1:0] bits
  );
    logic [sample_width-1:0] m;
    m = '0;
    for (int i = 0; i < sample_width; i++) begin
      if (i < int'(bits)) begin
        m[i] = 1'b1;
      end
    end
    return m;
  endfunction

endpackage

`default_nettype wire

/* source/dlc_top.sv */
`timescale 1ns/100ps
`default_nettype none

// level-crossing encoder between a sample FIFO and a packet FIFO
module dlc_top import dlc_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    in_push_i,
  input  wire logic [sample_width-1:0] in_data_i,
  output logic                         in_full_o,
  input  wire logic                    out_pop_i,
  output logic      [sample_width-1:0] out_data_o,
  output logic                         out_empty_o,
  input  wire logic [log_width_w-1:0]  log_wl_i,     // static config
  input  wire logic [field_bits_w-1:0] dlvl_bits_i,
  input  wire logic [field_bits_w-1:0] dt_bits_i,
  input  wire logic                    twoscomp_i
);

  logic [sample_width-1:0] in_sample;
  logic                    in_empty;
  logic                    in_pop;
  logic                    out_full;
  logic                    out_push;
  logic [sample_width-1:0] packet;
  logic                    xing;
  logic [sample_width-1:0] dlvl;
  logic [sample_width-1:0] dlvl_abs;
  logic                    dir;
  logic                    dlvl_ovf_det;  // fresh overflow on this pop
  logic                    ovf_end;
  dlc_state_e              state;
  logic [sample_width-1:0] dt_out;

  // sample side
  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_in_fifo (
    .clk_i, .rst_ni,
    .push_i(in_push_i), .data_i(in_data_i), .full_o(in_full_o),
    .pop_i(in_pop), .data_o(in_sample), .empty_o(in_empty)
  );

  level_tracker i_level_tracker (
    .clk_i, .rst_ni,
    .pop_i(in_pop), .sample_i(in_sample), .log_wl_i, .dlvl_bits_i,
    .xing_o(xing), .dlvl_o(dlvl), .dlvl_abs_o(dlvl_abs), .dir_o(dir),
    .dlvl_ovf_o(dlvl_ovf_det)
  );

  dlc_controller i_dlc_controller (
    .clk_i, .rst_ni,
    .in_empty_i(in_empty), .out_full_i(out_full), .xing_i(xing),
    .dlvl_ovf_i(dlvl_ovf_det), .ovf_end_i(ovf_end), .dt_bits_i,
    .pop_o(in_pop), .push_o(out_push), .state_o(state), .dt_o(dt_out)
  );

  packet_builder i_packet_builder (
    .clk_i, .rst_ni,
    .advance_i(~out_full), .state_i(state), .dlvl_ovf_i(dlvl_ovf_det),
    .dlvl_i(dlvl), .dlvl_abs_i(dlvl_abs), .dir_i(dir), .dt_i(dt_out),
    .dlvl_bits_i, .twoscomp_i,
    .ovf_end_o(ovf_end), .packet_o(packet)
  );

  // packet side
  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_out_fifo (
    .clk_i, .rst_ni,
    .push_i(out_push), .data_i(packet), .full_o(out_full),
    .pop_i(out_pop_i), .data_o(out_data_o), .empty_o(out_empty_o)
  );

endmodule

`default_nettype wire

/* source/level_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

// quantizes samples to levels and tracks level crossings
module level_tracker import dlc_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    pop_i,       // sample valid this cycle
  input  wire logic [sample_width-1:0] sample_i,
  input  wire logic [log_width_w-1:0]  log_wl_i,    // log2 of level width
  input  wire logic [field_bits_w-1:0] dlvl_bits_i, // delta-level field size
  output logic                         xing_o,
  output logic      [sample_width-1:0] dlvl_o,      // signed level delta
  output logic      [sample_width-1:0] dlvl_abs_o,
  output logic                         dir_o,       // 1 = downward
  output logic                         dlvl_ovf_o
);

  logic signed [sample_width-1:0] din_lvl;   // level of popped sample
  logic signed [sample_width-1:0] curr_lvl;  // last reported level
  logic signed [sample_width-1:0] dlvl;
  logic        [sample_width-1:0] dlvl_mask;

  assign dlvl_mask = field_mask(dlvl_bits_i);

  // arithmetic shift keeps the sign of the sample
  assign din_lvl = $signed(sample_i) >>> log_wl_i;

  always_comb begin
    // delta is forced to zero without a pop, so no spurious crossing
    if (pop_i) begin
      dlvl = din_lvl - curr_lvl;
    end else begin
      dlvl = '0;
    end
  end

  assign xing_o = (dlvl != '0);
  assign dlvl_o = dlvl;
  assign dir_o  = dlvl[sample_width-1];  // sign bit

  always_comb begin
    if (dlvl[sample_width-1]) begin
      dlvl_abs_o = ~dlvl + 1'b1;  // negate
    end else begin
      dlvl_abs_o = dlvl;
    end
  end

  // any magnitude bit above the field means the delta must be split
  assign dlvl_ovf_o = pop_i & (|(dlvl_abs_o & ~dlvl_mask));

  // reference level moves only on a crossing
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      curr_lvl <= '0;
    end else if (xing_o) begin
      curr_lvl <= din_lvl;
    end
  end

endmodule

`default_nettype wire

/* source/packet_builder.sv */
`timescale 1ns/100ps
`default_nettype none

// splits overflowing deltas and packs the output word
module packet_builder import dlc_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    advance_i,   // output FIFO has room
  input  wire dlc_state_e              state_i,
  input  wire logic                    dlvl_ovf_i,
  input  wire logic [sample_width-1:0] dlvl_i,
  input  wire logic [sample_width-1:0] dlvl_abs_i,
  input  wire logic                    dir_i,
  input  wire logic [sample_width-1:0] dt_i,
  input  wire logic [field_bits_w-1:0] dlvl_bits_i,
  input  wire logic                    twoscomp_i,  // 1 = two's complement field
  output logic                         ovf_end_o,
  output logic      [sample_width-1:0] packet_o
);

  logic [sample_width-1:0] dlvl_mask;
  logic [sample_width-1:0] ovf_cnt;    // magnitude still to send
  logic [sample_width-1:0] cnt_op;
  logic [sample_width-1:0] cnt_nxt;
  logic                    dir_q;      // direction held across pieces
  logic [sample_width-1:0] dlvl_field;
  logic                    dir_out;
  logic [sample_width:0]   dt_dir;     // one extra bit for dir
  logic [sample_width:0]   pkt_wide;

  assign dlvl_mask = field_mask(dlvl_bits_i);

  // first piece starts from the full magnitude
  assign cnt_op  = dlvl_ovf_i ? dlvl_abs_i : ovf_cnt;
  assign cnt_nxt = cnt_op - dlvl_mask;

  // last piece once the remainder fits in one field
  assign ovf_end_o = advance_i & (cnt_nxt[sample_width-1] | (cnt_nxt == '0));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ovf_cnt <= '0;
      dir_q   <= 1'b0;
    end else if (advance_i) begin
      if (dlvl_ovf_i) begin
        ovf_cnt <= cnt_nxt;
        dir_q   <= dir_i;
      end else if (state_i == dlvl_ovf) begin
        if (ovf_end_o) begin
          ovf_cnt <= '0;  // sequence done
        end else begin
          ovf_cnt <= cnt_nxt;
        end
      end else begin
        ovf_cnt <= '0;
        dir_q   <= 1'b0;
      end
    end
  end

  always_comb begin
    if (dlvl_ovf_i) begin
      dlvl_field = dlvl_mask;  // full piece
      dir_out    = dir_i;
    end else if (state_i == dlvl_ovf && !ovf_end_o) begin
      dlvl_field = dlvl_mask;
      dir_out    = dir_q;
    end else if (state_i == dlvl_ovf) begin
      dlvl_field = cnt_op & dlvl_mask;  // remainder piece
      dir_out    = dir_q;
    end else if (state_i == dt_ovf) begin
      dlvl_field = '0;  // time-only packet
      dir_out    = 1'b0;
    end else if (twoscomp_i) begin
      dlvl_field = dlvl_i & dlvl_mask;
      dir_out    = dir_i;
    end else begin
      dlvl_field = dlvl_abs_i & dlvl_mask;
      dir_out    = dir_i;
    end
  end

  always_comb begin
    // sign/magnitude keeps dir just above the field and two's complement drops it
    if (twoscomp_i) begin
      dt_dir = {1'b0, dt_i};
    end else begin
      dt_dir = {dt_i, dir_out};
    end
    pkt_wide = (dt_dir << dlvl_bits_i) | {1'b0, dlvl_field};
  end

  assign packet_o = pkt_wide[sample_width-1:0];  // upper dt bits fall off

endmodule

`default_nettype wire

/* source/sample_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

// circular buffer without fall-through
module sample_fifo import dlc_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 4  // power of two, at least 2
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    push_i,
  input  wire logic [sample_width-1:0] data_i,
  output logic                         full_o,
  input  wire logic                    pop_i,
  output logic      [sample_width-1:0] data_o,
  output logic                         empty_o
);

  localparam int unsigned ptr_w = $clog2(FIFO_DEPTH);
  localparam int unsigned cnt_w = ptr_w + 1;  // holds 0..FIFO_DEPTH

  logic [sample_width-1:0] mem [FIFO_DEPTH];  // storage
  logic [ptr_w-1:0]        wr_ptr;
  logic [ptr_w-1:0]        rd_ptr;
  logic [cnt_w-1:0]        cnt;     // occupancy
  logic                    push_ok; // push that is actually taken
  logic                    pop_ok;

  assign full_o  = (cnt == cnt_w'(FIFO_DEPTH));
  assign empty_o = (cnt == '0);
  assign push_ok = push_i & ~full_o;   // drop push when full
  assign pop_ok  = pop_i & ~empty_o;   // drop pop when empty
  assign data_o  = mem[rd_ptr];        // head of queue

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;  // none, or push and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_dlc.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dlc import dlc_pkg::*; ();

  typedef logic [sample_width-1:0] word_q_t [$];

  logic                    clk;
  logic                    rst_n;
  logic                    in_push;
  logic [sample_width-1:0] in_data;
  logic                    in_full;
  logic                    out_pop = 1'b0;  // owned by the checker
  logic [sample_width-1:0] out_data;
  logic                    out_empty;
  logic [log_width_w-1:0]  log_wl;
  logic [field_bits_w-1:0] dlvl_bits;
  logic [field_bits_w-1:0] dt_bits;
  logic                    twoscomp;

  int      seed;
  string   test_name = "reset";
  word_q_t exp_q;              // every packet expected so far, all tests
  int      chk_idx = 0;        // next entry of exp_q to compare
  bit      stall_pat [$];      // sink hold-off pattern
  int      stall_idx = 0;
  bit      stall_en = 1'b0;
  bit      hold;
  logic [sample_width-1:0] exp_word;
  int      cycle_cnt = 0;
  int      cycle_limit = 200;  // grows with each test
  int      mismatch_cnt = 0;
  int      extra_cnt = 0;
  int      missing_cnt = 0;
  int      idle_cnt = 0;

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  dlc_top #(.FIFO_DEPTH(4)) i_dlc_top (
    .clk_i(clk), .rst_ni(rst_n),
    .in_push_i(in_push), .in_data_i(in_data), .in_full_o(in_full),
    .out_pop_i(out_pop), .out_data_o(out_data), .out_empty_o(out_empty),
    .log_wl_i(log_wl), .dlvl_bits_i(dlvl_bits), .dt_bits_i(dt_bits),
    .twoscomp_i(twoscomp)
  );

  // sign/magnitude puts dir between dt and field
  function automatic logic [sample_width-1:0] pack_word(
    input int dt, input int field, input bit dir, input int nbits, input bit twos
  );
    logic [47:0] w;
    if (twos) begin
      w = (48'(dt) << nbits) | 48'(field);
    end else begin
      w = (((48'(dt) << 1) | 48'(dir)) << nbits) | 48'(field);
    end
    return w[sample_width-1:0];  // upper dt bits are lost
  endfunction

  // expected packet stream for one sample stream, starting from reset
  function automatic void encode_ref(
    input  word_q_t                 samples,
    input  logic [log_width_w-1:0]  lw,
    input  logic [field_bits_w-1:0] dlb,
    input  logic [field_bits_w-1:0] dtb,
    input  bit                      twos,
    output word_q_t                 pkts
  );
    int cur;
    int cnt;
    int s;
    int lvl;
    int d;
    int mag;
    int dt;
    int dmask;
    int tmask;
    bit dir;
    pkts  = {};
    cur   = 0;
    cnt   = 0;
    dmask = (1 << int'(dlb)) - 1;
    tmask = (1 << int'(dtb)) - 1;
    foreach (samples[i]) begin
      s   = int'($signed(samples[i]));
      lvl = s >>> int'(lw);
      if (lvl == cur) begin
        if (cnt == tmask) begin
          pkts.push_back(pack_word(tmask, 0, 1'b0, int'(dlb), twos));  // time overflow
          cnt = 1;
        end else begin
          cnt++;
        end
      end else begin
        d   = lvl - cur;
        dir = (d < 0);
        mag = dir ? -d : d;
        if (mag <= dmask) begin
          pkts.push_back(pack_word(cnt, twos ? (d & dmask) : mag, dir, int'(dlb), twos));
        end else begin
          dt = cnt;  // only the first piece carries the time
          while (mag > dmask) begin
            pkts.push_back(pack_word(dt, dmask, dir, int'(dlb), twos));
            mag = mag - dmask;
            dt  = 0;
          end
          pkts.push_back(pack_word(0, mag, dir, int'(dlb), twos));  // remainder
        end
        cur = lvl;
        cnt = 1;
      end
    end
  endfunction

  // kind 0 small steps, 1 big jumps, 2 flat runs, else steps with jumps
  task automatic gen_samples(input int kind, input int n, output word_q_t samples);
    int v;
    int hold_len;
    int step;
    samples  = {};
    v        = 0;
    hold_len = 0;
    for (int i = 0; i < n; i++) begin
      step = $random(seed) % 48;
      case (kind)
        0: begin
          if (step % 4 == 0) begin
            step = 0;  // some flat samples
          end
        end
        1: begin
          v    = $random(seed) % 2048;
          step = 0;
        end
        2: begin
          if (hold_len > 0) begin
            hold_len--;
            step = 0;
          end else begin
            hold_len = $random(seed) & 31;
            step     = step * 4;
          end
        end
        default: begin
          if (i % 8 == 7) begin
            step = $random(seed) % 1024;
          end
        end
      endcase
      v = v + step;
      if (v > 30000 || v < -30000) begin
        v = 0;  // stay clear of 16-bit wrap
      end
      samples.push_back(v[sample_width-1:0]);
    end
  endtask

  task automatic gen_stalls(input int len);
    int burst;
    burst = 0;
    for (int i = 0; i < len; i++) begin
      if (burst == 0 && ($random(seed) & 7) == 0) begin
        burst = 1 + ($random(seed) & 15);  // sink stays away 1..16 cycles
      end
      if (burst > 0) begin
        burst--;
        stall_pat.push_back(1'b1);
      end else begin
        stall_pat.push_back(1'b0);
      end
    end
  endtask

  task automatic apply_reset(
    input logic [log_width_w-1:0] lw, input logic [field_bits_w-1:0] dlb,
    input logic [field_bits_w-1:0] dtb, input bit twos
  );
    @(negedge clk);
    rst_n     = 1'b0;
    in_push   = 1'b0;
    log_wl    = lw;   // config only changes under reset
    dlvl_bits = dlb;
    dt_bits   = dtb;
    twoscomp  = twos;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic push_samples(input word_q_t samples);
    foreach (samples[i]) begin
      @(negedge clk);
      in_push = 1'b0;
      while (in_full) begin
        @(negedge clk);
      end
      in_push = 1'b1;
      in_data = samples[i];
    end
    @(negedge clk);
    in_push = 1'b0;
  endtask

  task automatic run_test(
    input string name, input int kind, input int n,
    input logic [log_width_w-1:0] lw, input logic [field_bits_w-1:0] dlb,
    input logic [field_bits_w-1:0] dtb, input bit twos, input bit stall
  );
    word_q_t samples;
    word_q_t pkts;
    int      quiet;  // cycles in a row with an empty output FIFO
    test_name = name;
    apply_reset(lw, dlb, dtb, twos);
    gen_samples(kind, n, samples);
    encode_ref(samples, lw, dlb, dtb, twos, pkts);
    cycle_limit += 8 * (samples.size() + pkts.size());
    if (stall) begin
      gen_stalls(8 * (samples.size() + pkts.size()));
    end
    foreach (pkts[i]) begin
      exp_q.push_back(pkts[i]);
    end
    stall_en = stall;
    push_samples(samples);
    quiet = 0;
    // all packets seen, or the DUT has gone quiet
    while (chk_idx < exp_q.size() && quiet < 32) begin
      @(negedge clk);
      if (out_empty) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    stall_en = 1'b0;
    repeat (10) @(negedge clk);  // stray packets would show up here
    assert (chk_idx == exp_q.size()) else begin
      $display("test %s: %0d expected packets never left the DUT",
               name, exp_q.size() - chk_idx);
      missing_cnt += exp_q.size() - chk_idx;
      chk_idx = exp_q.size();  // realign for the next test
    end
    $display("test %s: %0d samples, %0d packets", name, samples.size(), pkts.size());
  endtask

  // compares the head at the falling edge and pops it at the rising one
  always @(negedge clk) begin
    hold = 1'b0;
    if (stall_en && stall_idx < stall_pat.size()) begin
      hold = stall_pat[stall_idx];
      stall_idx++;
    end
    out_pop = 1'b0;
    if (rst_n && !out_empty && !hold) begin
      out_pop = 1'b1;
      assert (chk_idx < exp_q.size()) else begin
        $display("test %s: DUT sent packet %h that was not expected", test_name, out_data);
        extra_cnt++;
      end
      if (chk_idx < exp_q.size()) begin
        exp_word = exp_q[chk_idx];
        chk_idx++;
        assert (out_data == exp_word) else begin
          $display("ERROR %s: packet %0d expected %h, actual %h",
                   test_name, chk_idx - 1, exp_word, out_data);
          mismatch_cnt++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout in test %s after %0d cycles, %0d packets never arrived",
               test_name, cycle_cnt, exp_q.size() - chk_idx);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    seed      = 32'h57161f92;
    rst_n     = 1'b0;
    in_push   = 1'b0;
    in_data   = '0;
    log_wl    = 4'd3;
    dlvl_bits = 4'd6;
    dt_bits   = 4'd5;
    twoscomp  = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    test_name = "idle";
    repeat (20) begin
      @(negedge clk);
      assert (out_empty && !in_full) else begin
        $display("ERROR idle: expected empty=1 full=0, actual empty=%b full=%b",
                 out_empty, in_full);
        idle_cnt++;
      end
    end

    run_test("sm_steps", 0, 200, 4'd3, 4'd6, 4'd5, 1'b0, 1'b0);
    run_test("tc_steps", 0, 200, 4'd3, 4'd6, 4'd5, 1'b1, 1'b0);
    run_test("dlvl_split", 1, 40, 4'd4, 4'd3, 4'd6, 1'b0, 1'b0);
    run_test("dt_overflow", 2, 200, 4'd5, 4'd5, 4'd3, 1'b0, 1'b0);
    run_test("backpressure", 3, 200, 4'd3, 4'd4, 4'd4, 1'b0, 1'b1);

    $display("errors: %0d mismatched, %0d unexpected, %0d missing, %0d idle",
             mismatch_cnt, extra_cnt, missing_cnt, idle_cnt);
    if (mismatch_cnt + extra_cnt + missing_cnt + idle_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
